/* hdl/stream_pkg.sv */
// ---------------------------------------------------------
// stream package
// bus-level constants and types of the byte stream.
// ---------------------------------------------------------

`default_nettype none

package stream_pkg;

   // ---------------------------------------------------------
   // bus geometry
   // ---------------------------------------------------------

   // bus width in bytes.
   localparam int data_bytes = 8;

   // wide enough for a count of 0 to data_bytes.
   localparam int count_wid = 4;

   // ---------------------------------------------------------
   // word types
   // ---------------------------------------------------------

   // one bus word with byte 0 in the low bits.
   typedef logic [data_bytes*8-1:0] data_t;

   // byte-valid mask where bit i qualifies byte i.
   typedef logic [data_bytes-1:0] keep_t;

   // byte count or shift amount.
   typedef logic [count_wid-1:0] count_t;

endpackage

`default_nettype wire

/* hdl/join_pkg.sv */
// ---------------------------------------------------------
// join package
// state and opcode encodings of the header/payload join.
// ---------------------------------------------------------

`default_nettype none

package join_pkg;

   // input stream currently being consumed.
   typedef enum logic [1:0] {
      HEADER,
      PAYLOAD
   } join_state_t;

   // ---------------------------------------------------------
   // merge opcodes issued once per accepted input word
   // ---------------------------------------------------------
   typedef enum logic [1:0] {
      OP_IDLE,
      OP_HDR_FULL,
      OP_HDR_TAIL,
      OP_PYLD
   } merge_op_t;

endpackage

`default_nettype wire

/* hdl/byte_stream_if.sv */
// ---------------------------------------------------------
// byte stream interface
// valid/ready word stream with byte mask and end of packet.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

   logic              tvalid;
   stream_pkg::data_t tdata;
   stream_pkg::keep_t tkeep;
   logic              tlast;
   logic              tready;

   // sending side.
   modport tx (
      output tvalid, tdata, tkeep, tlast,
      input  tready
   );

   // receiving side.
   modport rx (
      input  tvalid, tdata, tkeep, tlast,
      output tready
   );

endinterface

`default_nettype wire

/* hdl/stream_reg_stage.sv */
// ---------------------------------------------------------
// stream register stage
// main plus skid register, registered tready, full rate.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module stream_reg_stage (
   input  logic        clk,
   input  logic        reset,
   byte_stream_if.rx   up,
   byte_stream_if.tx   down
);

   logic              main_valid, main_valid_n;
   logic              skid_valid, skid_valid_n;
   logic              ready_r;
   logic              up_fire;
   logic              load_main, main_from_skid, load_skid;
   stream_pkg::data_t skid_data;
   stream_pkg::keep_t skid_keep;
   logic              skid_last;

   assign up_fire   = up.tvalid && ready_r;
   assign up.tready = ready_r;
   assign down.tvalid = main_valid;

   // ---------------------------------------------------------
   // next state of the two slots
   // ---------------------------------------------------------
   always_comb begin
      main_valid_n   = main_valid;
      skid_valid_n   = skid_valid;
      load_main      = 1'b0;
      main_from_skid = 1'b0;
      load_skid      = 1'b0;
      if (!main_valid || down.tready) begin
         // main slot is free this cycle, drain the skid first.
         load_main      = skid_valid || up_fire;
         main_from_skid = skid_valid;
         main_valid_n   = skid_valid || up_fire;
         skid_valid_n   = 1'b0;
      end else if (up_fire) begin
         load_skid    = 1'b1;
         skid_valid_n = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
         ready_r    <= 1'b0;
      end else begin
         main_valid <= main_valid_n;
         skid_valid <= skid_valid_n;
         ready_r    <= !skid_valid_n;
      end
   end

   // payload registers.
   always_ff @(posedge clk) begin
      if (load_main) begin
         down.tdata <= main_from_skid ? skid_data : up.tdata;
         down.tkeep <= main_from_skid ? skid_keep : up.tkeep;
         down.tlast <= main_from_skid ? skid_last : up.tlast;
      end
      if (load_skid) begin
         skid_data <= up.tdata;
         skid_keep <= up.tkeep;
         skid_last <= up.tlast;
      end
   end

endmodule

`default_nettype wire

/* hdl/join_fsm.sv */
// ---------------------------------------------------------
// join FSM
// consumes the header, then the payload of each packet,
// and issues one merge opcode per accepted word.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module join_fsm (
   input  logic                clk,
   input  logic                reset,
   byte_stream_if.rx           hdr,
   byte_stream_if.rx           pyld,
   input  logic                merge_ready,
   output join_pkg::merge_op_t op,
   output stream_pkg::data_t   word_data,
   output stream_pkg::keep_t   word_keep,
   output logic                word_last
);

   join_pkg::join_state_t state, state_n;

   logic hdr_fire;
   logic pyld_fire;

   // ---------------------------------------------------------
   // handshake with the input stages
   // ---------------------------------------------------------

   // only the selected stream sees ready.
   assign hdr.tready  = (state == join_pkg::HEADER) && merge_ready;
   assign pyld.tready = (state == join_pkg::PAYLOAD) && merge_ready;

   assign hdr_fire  = hdr.tvalid && hdr.tready;
   assign pyld_fire = pyld.tvalid && pyld.tready;

   // word of the selected stream goes to the merge.
   always_comb begin
      if (state == join_pkg::HEADER) begin
         word_data = hdr.tdata;
         word_keep = hdr.tkeep;
         word_last = hdr.tlast;
      end else begin
         word_data = pyld.tdata;
         word_keep = pyld.tkeep;
         word_last = pyld.tlast;
      end
   end

   // ---------------------------------------------------------
   // opcode and next state
   // ---------------------------------------------------------
   always_comb begin
      op      = join_pkg::OP_IDLE;
      state_n = state;
      case (state)
         join_pkg::HEADER: begin
            if (hdr_fire) begin
               if (hdr.tlast) begin
                  // leftover header bytes wait for the payload.
                  op      = join_pkg::OP_HDR_TAIL;
                  state_n = join_pkg::PAYLOAD;
               end else begin
                  op = join_pkg::OP_HDR_FULL;
               end
            end
         end
         join_pkg::PAYLOAD: begin
            if (pyld_fire) begin
               op = join_pkg::OP_PYLD;
               if (pyld.tlast) begin
                  state_n = join_pkg::HEADER;
               end
            end
         end
         default: begin
            state_n = join_pkg::HEADER;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= join_pkg::HEADER;
      end else begin
         state <= state_n;
      end
   end

endmodule

`default_nettype wire

/* hdl/byte_merge.sv */
// ---------------------------------------------------------
// byte merge
// carry register and byte shifter, packs header tail and
// payload bytes into full output words.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module byte_merge (
   input  logic                clk,
   input  logic                reset,
   input  join_pkg::merge_op_t op,
   input  stream_pkg::data_t   word_data,
   input  stream_pkg::keep_t   word_keep,
   input  logic                word_last,
   output logic                merge_ready,
   byte_stream_if.tx           merged
);

   stream_pkg::data_t  carry_data, carry_data_n;
   stream_pkg::count_t carry_cnt, carry_cnt_n;
   logic               pending, pending_n;
   stream_pkg::count_t pyld_cnt, total_cnt;
   stream_pkg::data_t  shifted_data, spill_data, joined_data;

   // no new word while the spilled tail is still going out.
   assign merge_ready = merged.tready && !pending;

   // ---------------------------------------------------------
   // byte shifter
   // ---------------------------------------------------------
   assign pyld_cnt     = keep_to_count(word_keep);
   assign total_cnt    = carry_cnt + pyld_cnt;
   assign shifted_data = word_data << (8 * carry_cnt);
   // payload bytes that do not fit behind the carry.
   assign spill_data   = word_data >> (8 * (stream_pkg::data_bytes - int'(carry_cnt)));

   always_comb begin
      for (int i = 0; i < stream_pkg::data_bytes; i++) begin
         if (i < carry_cnt) begin
            joined_data[8*i +: 8] = carry_data[8*i +: 8];
         end else begin
            joined_data[8*i +: 8] = shifted_data[8*i +: 8];
         end
      end
   end

   // ---------------------------------------------------------
   // output word and carry update
   // ---------------------------------------------------------
   always_comb begin
      merged.tvalid = 1'b0;
      merged.tdata  = word_data;
      merged.tkeep  = word_keep;
      merged.tlast  = 1'b0;
      carry_data_n  = carry_data;
      carry_cnt_n   = carry_cnt;
      pending_n     = pending;
      if (pending) begin
         // last bytes of the packet, spilled from the previous word.
         merged.tvalid = 1'b1;
         merged.tdata  = carry_data;
         merged.tkeep  = count_to_keep(carry_cnt);
         merged.tlast  = 1'b1;
         if (merged.tready) begin
            pending_n   = 1'b0;
            carry_cnt_n = '0;
         end
      end else begin
         case (op)
            join_pkg::OP_HDR_FULL: begin
               merged.tvalid = 1'b1;
            end
            join_pkg::OP_HDR_TAIL: begin
               if (&word_keep) begin
                  merged.tvalid = 1'b1;
               end else begin
                  carry_data_n = word_data;
                  carry_cnt_n  = pyld_cnt;
               end
            end
            join_pkg::OP_PYLD: begin
               merged.tdata = joined_data;
               if (word_last && total_cnt <= stream_pkg::data_bytes) begin
                  merged.tvalid = 1'b1;
                  merged.tkeep  = count_to_keep(total_cnt);
                  merged.tlast  = 1'b1;
                  carry_cnt_n   = '0;
               end else if (total_cnt >= stream_pkg::data_bytes) begin
                  merged.tvalid = 1'b1;
                  merged.tkeep  = '1;
                  carry_data_n  = spill_data;
                  carry_cnt_n   = stream_pkg::count_t'(total_cnt - stream_pkg::data_bytes);
                  pending_n     = word_last;
               end else begin
                  carry_data_n = joined_data;
                  carry_cnt_n  = total_cnt;
               end
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         carry_cnt <= '0;
         pending   <= 1'b0;
      end else begin
         carry_cnt <= carry_cnt_n;
         pending   <= pending_n;
      end
   end

   always_ff @(posedge clk) begin
      carry_data <= carry_data_n;
   end

   // number of valid bytes in a contiguous low mask.
   function automatic stream_pkg::count_t keep_to_count(input stream_pkg::keep_t keep);
      stream_pkg::count_t cnt;
      cnt = '0;
      for (int i = 0; i < stream_pkg::data_bytes; i++) begin
         if (keep[i]) begin
            cnt = stream_pkg::count_t'(i + 1);
         end
      end
      return cnt;
   endfunction

   // contiguous low mask of cnt bytes.
   function automatic stream_pkg::keep_t count_to_keep(input stream_pkg::count_t cnt);
      stream_pkg::keep_t keep;
      for (int i = 0; i < stream_pkg::data_bytes; i++) begin
         keep[i] = (i < cnt);
      end
      return keep;
   endfunction

endmodule

`default_nettype wire

/* hdl/stream_join.sv */
// ---------------------------------------------------------
// stream join
// rejoins a header stream and a payload stream into one
// packed byte stream with no gap between them.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module stream_join (
   input  logic              clk,
   input  logic              reset,

   input  logic              hdr_valid,
   input  stream_pkg::data_t hdr_data,
   input  stream_pkg::keep_t hdr_keep,
   input  logic              hdr_last,
   output logic              hdr_ready,

   input  logic              pyld_valid,
   input  stream_pkg::data_t pyld_data,
   input  stream_pkg::keep_t pyld_keep,
   input  logic              pyld_last,
   output logic              pyld_ready,

   output logic              out_valid,
   output stream_pkg::data_t out_data,
   output stream_pkg::keep_t out_keep,
   output logic              out_last,
   input  logic              out_ready
);

   byte_stream_if hdr_in_s ();
   byte_stream_if pyld_in_s ();
   byte_stream_if hdr_s ();
   byte_stream_if pyld_s ();
   byte_stream_if merged_s ();
   byte_stream_if out_s ();

   join_pkg::merge_op_t op;
   stream_pkg::data_t   word_data;
   stream_pkg::keep_t   word_keep;
   logic                word_last;
   logic                merge_ready;

   // ---------------------------------------------------------
   // port to interface wiring
   // ---------------------------------------------------------
   assign hdr_in_s.tvalid  = hdr_valid;
   assign hdr_in_s.tdata   = hdr_data;
   assign hdr_in_s.tkeep   = hdr_keep;
   assign hdr_in_s.tlast   = hdr_last;
   assign hdr_ready        = hdr_in_s.tready;

   assign pyld_in_s.tvalid = pyld_valid;
   assign pyld_in_s.tdata  = pyld_data;
   assign pyld_in_s.tkeep  = pyld_keep;
   assign pyld_in_s.tlast  = pyld_last;
   assign pyld_ready       = pyld_in_s.tready;

   assign out_valid        = out_s.tvalid;
   assign out_data         = out_s.tdata;
   assign out_keep         = out_s.tkeep;
   assign out_last         = out_s.tlast;
   assign out_s.tready     = out_ready;

   // ---------------------------------------------------------
   // datapath
   // ---------------------------------------------------------
   stream_reg_stage hdr_stage (.clk, .reset, .up(hdr_in_s), .down(hdr_s));

   stream_reg_stage pyld_stage (.clk, .reset, .up(pyld_in_s), .down(pyld_s));

   join_fsm join_fsm_0 (
      .clk, .reset,
      .hdr         (hdr_s),
      .pyld        (pyld_s),
      .merge_ready (merge_ready),
      .op          (op),
      .word_data   (word_data),
      .word_keep   (word_keep),
      .word_last   (word_last)
   );

   byte_merge byte_merge_0 (
      .clk, .reset,
      .op          (op),
      .word_data   (word_data),
      .word_keep   (word_keep),
      .word_last   (word_last),
      .merge_ready (merge_ready),
      .merged      (merged_s)
   );

   stream_reg_stage out_stage (.clk, .reset, .up(merged_s), .down(out_s));

endmodule

`default_nettype wire

/* test/stream_join_properties.sv */
// ---------------------------------------------------------
// stream join properties
// protocol assertions on the output stream of the join.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module stream_join_properties (
   input logic              clk,
   input logic              reset,
   input logic              out_valid,
   input stream_pkg::data_t out_data,
   input stream_pkg::keep_t out_keep,
   input logic              out_last,
   input logic              out_ready
);

   // failures seen so far, read at the end of the run.
   int assert_errors = 0;

   // a stalled word stays put until it transfers.
   hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data)
         && $stable(out_keep) && $stable(out_last))
      else begin
         $error("output word changed while out_ready was low");
         assert_errors++;
      end

   keep_not_empty: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> out_keep != '0)
      else begin
         $error("output word with an empty byte mask");
         assert_errors++;
      end

   // a low run of ones plus one has no bit in common with itself.
   keep_contiguous: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> (out_keep & (out_keep + 1'b1)) == '0)
      else begin
         $error("output byte mask is not a contiguous low run");
         assert_errors++;
      end

   idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
      else begin
         $error("out_valid high in the cycle after reset");
         assert_errors++;
      end

endmodule

bind stream_join stream_join_properties props (
   .clk       (clk),
   .reset     (reset),
   .out_valid (out_valid),
   .out_data  (out_data),
   .out_keep  (out_keep),
   .out_last  (out_last),
   .out_ready (out_ready)
);

`default_nettype wire

/* test/stream_join_checker.sv */
// ---------------------------------------------------------
// stream join checker
// compares every output word against a queue of expected bytes.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module stream_join_checker (
   input logic              clk,
   input logic              reset,
   input logic              out_valid,
   input stream_pkg::data_t out_data,
   input stream_pkg::keep_t out_keep,
   input logic              out_last,
   input logic              out_ready
);

   logic [7:0] exp_q[$];
   int         len_q[$];
   int         error_count = 0;
   int         pass_count = 0;
   int         fail_count = 0;
   int         pkts_done = 0;
   int         pkt_bytes = 0;
   int         pkt_words = 0;
   int         pkt_errors = 0;

   // model side, filled by the testbench before the run.
   task automatic expect_packet(input int len);
      len_q.push_back(len);
   endtask

   task automatic expect_byte(input logic [7:0] b);
      exp_q.push_back(b);
   endtask

   // ---------------------------------------------------------
   // one transferred output word
   // ---------------------------------------------------------
   task automatic check_word();
      int                remain;
      stream_pkg::keep_t exp_keep;
      logic              exp_last;
      logic [7:0]        exp_b;
      if (len_q.size() == 0) begin
         $display("unexpected output word after the last packet");
         error_count++;
         return;
      end
      // every word is full except the last, which holds what is left.
      remain   = len_q[0] - pkt_bytes;
      exp_last = (remain <= stream_pkg::data_bytes);
      for (int i = 0; i < stream_pkg::data_bytes; i++) begin
         exp_keep[i] = (i < remain);
      end
      if (out_keep !== exp_keep || out_last !== exp_last) begin
         $display("Fail packet %0d word %0d keep/last: expected 0x%02h/%0b, actual 0x%02h/%0b",
                  pkts_done, pkt_words, exp_keep, exp_last, out_keep, out_last);
         error_count++;
         pkt_errors++;
      end
      for (int i = 0; i < stream_pkg::data_bytes; i++) begin
         if (exp_keep[i]) begin
            exp_b = exp_q.pop_front();
            if (out_data[8*i +: 8] !== exp_b) begin
               $display("Fail packet %0d byte %0d: expected 0x%02h, actual 0x%02h",
                        pkts_done, pkt_bytes, exp_b, out_data[8*i +: 8]);
               error_count++;
               pkt_errors++;
            end
            pkt_bytes++;
         end
      end
      pkt_words++;
      if (exp_last) begin
         if (pkt_errors == 0) begin
            $display("ok   packet %0d: %0d bytes in %0d words", pkts_done, pkt_bytes, pkt_words);
            pass_count++;
         end else begin
            $display("packet %0d had %0d errors", pkts_done, pkt_errors);
            fail_count++;
         end
         void'(len_q.pop_front());
         pkts_done++;
         pkt_bytes  = 0;
         pkt_words  = 0;
         pkt_errors = 0;
      end
   endtask

   always @(posedge clk) begin
      if (!reset && out_valid && out_ready) begin
         check_word();
      end
   end

endmodule

`default_nettype wire

/* test/stream_join_tb.sv */
// ---------------------------------------------------------
// stream join testbench
// random header and payload packets, random back-pressure.
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module stream_join_tb;

   localparam int num_pkts    = 200;
   localparam int max_hdr     = 24;
   localparam int max_pyld    = 40;
   localparam int timeout_cyc = 10000;

   logic              clk = 1'b0;
   logic              reset = 1'b1;
   logic              hdr_valid = 1'b0, hdr_last = 1'b0, hdr_ready;
   stream_pkg::data_t hdr_data = '0;
   stream_pkg::keep_t hdr_keep = '0;
   logic              pyld_valid = 1'b0, pyld_last = 1'b0, pyld_ready;
   stream_pkg::data_t pyld_data = '0;
   stream_pkg::keep_t pyld_keep = '0;
   logic              out_valid, out_last, out_ready = 1'b0;
   stream_pkg::data_t out_data;
   stream_pkg::keep_t out_keep;

   logic [7:0] hdr_mem [num_pkts][max_hdr];
   logic [7:0] pyld_mem [num_pkts][max_pyld];
   int         hdr_len [num_pkts];
   int         pyld_len [num_pkts];
   bit         stalled = 1'b0;

   always #50 clk = ~clk;

   stream_join DUT (.*);

   stream_join_checker chk (.*);

   // ---------------------------------------------------------
   // stimulus helpers
   // ---------------------------------------------------------

   // word w of one stream of packet p, unused bytes hold noise.
   function automatic void make_word(input bit is_pyld, input int p, input int w,
                                     output stream_pkg::data_t data,
                                     output stream_pkg::keep_t keep, output logic last);
      int len;
      int idx;
      len = is_pyld ? pyld_len[p] : hdr_len[p];
      for (int i = 0; i < stream_pkg::data_bytes; i++) begin
         idx     = w * stream_pkg::data_bytes + i;
         keep[i] = (idx < len);
         if (idx >= len) begin
            data[8*i +: 8] = 8'($urandom);
         end else if (is_pyld) begin
            data[8*i +: 8] = pyld_mem[p][idx];
         end else begin
            data[8*i +: 8] = hdr_mem[p][idx];
         end
      end
      last = ((w + 1) * stream_pkg::data_bytes >= len);
   endfunction

   task automatic drive_word(input bit is_pyld, input logic valid, input stream_pkg::data_t data,
                             input stream_pkg::keep_t keep, input logic last);
      if (is_pyld) begin
         pyld_valid <= valid;
         pyld_data  <= data;
         pyld_keep  <= keep;
         pyld_last  <= last;
      end else begin
         hdr_valid <= valid;
         hdr_data  <= data;
         hdr_keep  <= keep;
         hdr_last  <= last;
      end
   endtask

   task automatic wait_accept(input bit is_pyld, input int p, output bit ok);
      int cnt;
      cnt = 0;
      ok  = 1'b0;
      while (!ok && cnt < timeout_cyc) begin
         @(posedge clk);
         cnt++;
         ok = is_pyld ? pyld_ready : hdr_ready;
      end
      if (!ok) begin
         $display("%s input stalled at packet %0d", is_pyld ? "payload" : "header", p);
         stalled = 1'b1;
      end
   endtask

   task automatic send_stream(input bit is_pyld);
      stream_pkg::data_t data;
      stream_pkg::keep_t keep;
      logic              last;
      int                nwords;
      int                idle;
      bit                ok;
      ok = 1'b1;
      for (int p = 0; p < num_pkts && ok; p++) begin
         nwords = ((is_pyld ? pyld_len[p] : hdr_len[p]) + 7) / 8;
         for (int w = 0; w < nwords && ok; w++) begin
            idle = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 4) : 0;
            if (idle > 0) begin
               drive_word(is_pyld, 1'b0, '0, '0, 1'b0);
               repeat (idle) @(posedge clk);
            end
            make_word(is_pyld, p, w, data, keep, last);
            drive_word(is_pyld, 1'b1, data, keep, last);
            wait_accept(is_pyld, p, ok);
         end
      end
      drive_word(is_pyld, 1'b0, '0, '0, 1'b0);
   endtask

   task automatic drive_ready();
      forever begin
         @(posedge clk);
         out_ready <= ($urandom_range(0, 1) == 1);
      end
   endtask

   // the count of finished packets must keep moving.
   task automatic wait_output();
      int cnt;
      int seen;
      cnt  = 0;
      seen = 0;
      while (chk.pkts_done < num_pkts && cnt < timeout_cyc) begin
         @(negedge clk);
         if (chk.pkts_done != seen) begin
            seen = chk.pkts_done;
            cnt  = 0;
         end else begin
            cnt++;
         end
      end
      if (chk.pkts_done < num_pkts) begin
         $display("output stalled waiting for packet %0d", chk.pkts_done);
         stalled = 1'b1;
      end
   endtask

   // ---------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------
   initial begin
      void'($urandom(32'h7af3));
      for (int p = 0; p < num_pkts; p++) begin
         hdr_len[p]  = $urandom_range(1, max_hdr);
         pyld_len[p] = $urandom_range(1, max_pyld);
         chk.expect_packet(hdr_len[p] + pyld_len[p]);
         for (int i = 0; i < hdr_len[p]; i++) begin
            hdr_mem[p][i] = 8'($urandom);
            chk.expect_byte(hdr_mem[p][i]);
         end
         for (int i = 0; i < pyld_len[p]; i++) begin
            pyld_mem[p][i] = 8'($urandom);
            chk.expect_byte(pyld_mem[p][i]);
         end
      end
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      fork
         drive_ready();
      join_none
      fork
         send_stream(1'b0);
         send_stream(1'b1);
         wait_output();
      join
      // stray extra words would show up here.
      repeat (20) @(posedge clk);
      $display("packets: %0d passed, %0d failed; errors: %0d checker, %0d assertion",
               chk.pass_count, chk.fail_count, chk.error_count, DUT.props.assert_errors);
      if (!stalled && chk.error_count == 0 && DUT.props.assert_errors == 0
          && chk.pass_count == num_pkts) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
hdl/stream_pkg.sv
hdl/join_pkg.sv
hdl/byte_stream_if.sv
hdl/stream_reg_stage.sv
hdl/join_fsm.sv
hdl/byte_merge.sv
hdl/stream_join.sv
test/stream_join_properties.sv
test/stream_join_checker.sv
test/stream_join_tb.sv
